//--- hdl/rs_defines.svh
// sizing macros for the reservation station core
//   station depth, physical tag width, datapath width
`ifndef RS_DEFINES_SVH
`define RS_DEFINES_SVH

// ====================================================================
// station geometry
// ====================================================================

// number of slots in the reservation station
`define RS_DEPTH 8

// ====================================================================
// datapath widths
// ====================================================================

// physical register tag, shared by dest and source operands
`define TAG_W 6

// integer datapath width
`define XLEN 32

`endif

//--- hdl/rs_pkg.sv
// shared types for the reservation station core
//   opcode and speculation enums
//   operand, dispatch, slot, issue and cdb structs
`include "rs_defines.svh"

package rs_pkg;

    // alu operations, beq also opens a speculation window
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLL = 3'd5,
        OP_SLT = 3'd6,
        OP_BEQ = 3'd7
    } opcode_e;

    // one level of branch speculation
    typedef enum logic {
        SPEC_IDLE    = 1'b0,
        SPEC_PENDING = 1'b1
    } spec_state_e;

    // source operand, value is meaningful only when rdy is set
    typedef struct packed {
        logic              rdy;
        logic [`TAG_W-1:0] tag;
        logic [`XLEN-1:0]  value;
    } operand_t;

    // renamed instruction as handed over by dispatch
    typedef struct packed {
        opcode_e           op;
        logic [`TAG_W-1:0] dest;
        operand_t          src_a;
        operand_t          src_b;
    } disp_pkt_t;

    // station slot contents as seen by the selectors
    typedef struct packed {
        logic      valid;
        logic      spec;
        disp_pkt_t pkt;
    } rs_slot_t;

    // issue packet to the alu
    typedef struct packed {
        logic              valid;
        opcode_e           op;
        logic [`TAG_W-1:0] dest;
        logic [`XLEN-1:0]  a;
        logic [`XLEN-1:0]  b;
        logic              spec;
    } issue_pkt_t;

    // common data bus, valid-only broadcast
    typedef struct packed {
        logic              valid;
        logic [`TAG_W-1:0] tag;
        logic [`XLEN-1:0]  value;
    } cdb_t;

endpackage

//--- hdl/rs_control.sv
// branch speculation control for the reservation station
//   two-state fsm, dispatch handshake, write strobe
//   speculation mark, squash and clear strobes
`timescale 1ns/100ps
`include "rs_defines.svh"

module rs_control import rs_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  logic    disp_valid_i,
    input  opcode_e disp_op_i,
    input  logic    any_free_i,
    input  logic    branch_resolve_i,
    input  logic    mispredict_i,
    input  logic    flush_i,
    output logic    disp_ready_o,
    output logic    write_o,
    output logic    spec_mark_o,
    output logic    squash_o,
    output logic    clear_spec_o
);

    spec_state_e state_q;
    spec_state_e state_d;
    logic        pending;
    logic        resolve;

    // ====================================================================
    // handshake and strobes
    // ====================================================================

    assign pending = (state_q == SPEC_PENDING);

    // resolve only counts while a branch is outstanding
    assign resolve = pending && branch_resolve_i;

    // stall on a full station or on a second branch
    assign disp_ready_o = any_free_i && !(pending && (disp_op_i == OP_BEQ));
    assign write_o      = disp_valid_i && disp_ready_o;

    // a dispatch that coincides with the resolve is already non-speculative
    assign spec_mark_o = pending && !resolve;

    // flush kills every stage, so it rides on the squash strobe too
    assign squash_o     = (resolve && mispredict_i) || flush_i;
    assign clear_spec_o = resolve && !mispredict_i;

    // ====================================================================
    // speculation fsm
    // ====================================================================

    always_comb begin
        state_d = state_q;
        if (flush_i) begin
            state_d = SPEC_IDLE;
        end else if (resolve) begin
            state_d = SPEC_IDLE;
        end else if (write_o && (disp_op_i == OP_BEQ)) begin
            // branch itself is accepted unmarked, later ones get marked
            state_d = SPEC_PENDING;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= SPEC_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

//--- hdl/rs_entry.sv
// single reservation station slot
//   allocation, issue and squash of the slot
//   cdb snooping for missing source operands
//   speculation mark tracking
`timescale 1ns/100ps
`include "rs_defines.svh"

module rs_entry import rs_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      write_i,
    input  disp_pkt_t pkt_i,
    input  logic      spec_i,
    input  logic      issue_i,
    input  logic      squash_i,
    input  logic      clear_spec_i,
    input  logic      flush_i,
    input  cdb_t      cdb_i,
    output rs_slot_t  slot_o,
    output logic      empty_o,
    output logic      ready_o
);

    logic      valid_q;
    logic      spec_q;
    disp_pkt_t pkt_q;
    disp_pkt_t pkt_d;

    // latch a broadcast value into a waiting operand on tag match
    function automatic operand_t snoop(operand_t opnd, cdb_t bus);
        operand_t res;
        res = opnd;
        if (!opnd.rdy && bus.valid && (bus.tag == opnd.tag)) begin
            res.rdy   = 1'b1;
            res.value = bus.value;
        end
        return res;
    endfunction

    // ====================================================================
    // slot control
    // ====================================================================

    always_ff @(posedge clock) begin
        if (reset || flush_i) begin
            valid_q <= 1'b0;
            spec_q  <= 1'b0;
        end else if (write_i) begin
            // allocation only ever targets an empty slot
            valid_q <= 1'b1;
            spec_q  <= spec_i;
        end else begin
            // leaves on issue, or on mispredict when marked
            if (issue_i || (squash_i && spec_q)) begin
                valid_q <= 1'b0;
            end
            // correct prediction, entry becomes non-speculative
            if (clear_spec_i) begin
                spec_q <= 1'b0;
            end
        end
    end

    // ====================================================================
    // payload and operand capture
    // ====================================================================

    always_comb begin
        pkt_d = pkt_q;
        if (write_i) begin
            // a broadcast in the dispatch cycle must not be missed
            pkt_d       = pkt_i;
            pkt_d.src_a = snoop(pkt_i.src_a, cdb_i);
            pkt_d.src_b = snoop(pkt_i.src_b, cdb_i);
        end else if (valid_q) begin
            pkt_d.src_a = snoop(pkt_q.src_a, cdb_i);
            pkt_d.src_b = snoop(pkt_q.src_b, cdb_i);
        end
    end

    always_ff @(posedge clock) begin
        pkt_q <= pkt_d;
    end

    // ====================================================================
    // outputs
    // ====================================================================

    assign slot_o.valid = valid_q;
    assign slot_o.spec  = spec_q;
    assign slot_o.pkt   = pkt_q;

    assign empty_o = !valid_q;
    assign ready_o = valid_q && pkt_q.src_a.rdy && pkt_q.src_b.rdy;

endmodule

//--- hdl/dispatch_select.sv
// allocation selector for the reservation station
//   lowest-numbered empty slot as a one-hot vector
//   free-slot indication for the dispatch handshake
`timescale 1ns/100ps
`include "rs_defines.svh"

module dispatch_select import rs_pkg::*; (
    input  logic [`RS_DEPTH-1:0] empty_vec_i,
    output logic [`RS_DEPTH-1:0] alloc_vec_o,
    output logic                 any_free_o
);

    logic found;

    // ====================================================================
    // priority encoder
    // ====================================================================

    // slot 0 has the highest priority
    always_comb begin
        alloc_vec_o = '0;
        found       = 1'b0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (empty_vec_i[i] && !found) begin
                alloc_vec_o[i] = 1'b1;
                found          = 1'b1;
            end
        end
    end

    // dispatch validity is applied later by the write strobe
    assign any_free_o = found;

endmodule

//--- hdl/issue_select.sv
// issue selector for the reservation station
//   lowest-numbered ready slot wins
//   builds the alu issue packet
//   returns a one-hot grant to the slots
`timescale 1ns/100ps
`include "rs_defines.svh"

module issue_select import rs_pkg::*; (
    input  rs_slot_t [`RS_DEPTH-1:0] slots_i,
    input  logic     [`RS_DEPTH-1:0] ready_vec_i,
    output logic     [`RS_DEPTH-1:0] grant_o,
    output issue_pkt_t               issue_pkt_o
);

    // ====================================================================
    // grant and packet mux
    // ====================================================================

    always_comb begin
        grant_o     = '0;
        // invalid packet when nothing is ready
        issue_pkt_o = '0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            // first ready slot from the bottom
            if (ready_vec_i[i] && !issue_pkt_o.valid) begin
                grant_o[i]        = 1'b1;
                issue_pkt_o.valid = 1'b1;
                issue_pkt_o.op    = slots_i[i].pkt.op;
                issue_pkt_o.dest  = slots_i[i].pkt.dest;
                // both operands are captured once ready is set
                issue_pkt_o.a     = slots_i[i].pkt.src_a.value;
                issue_pkt_o.b     = slots_i[i].pkt.src_b.value;
                // alu needs the mark to drop squashed work
                issue_pkt_o.spec  = slots_i[i].spec;
            end
        end
    end

endmodule

//--- hdl/int_alu.sv
// single-cycle integer alu stage
//   evaluates all opcodes on the issue packet
//   registers the result as a one-cycle cdb broadcast
//   drops marked work on squash, empties on flush
`timescale 1ns/100ps
`include "rs_defines.svh"

module int_alu import rs_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  issue_pkt_t issue_pkt_i,
    input  logic       squash_i,
    input  logic       clear_spec_i,
    input  logic       flush_i,
    output cdb_t       cdb_o
);

    logic [`XLEN-1:0]  result;
    logic              res_valid_q;
    logic              res_spec_q;
    logic [`TAG_W-1:0] res_tag_q;
    logic [`XLEN-1:0]  res_value_q;

    // ====================================================================
    // execute
    // ====================================================================

    always_comb begin
        case (issue_pkt_i.op)
            OP_ADD:  result = issue_pkt_i.a + issue_pkt_i.b;
            OP_SUB:  result = issue_pkt_i.a - issue_pkt_i.b;
            OP_AND:  result = issue_pkt_i.a & issue_pkt_i.b;
            OP_OR:   result = issue_pkt_i.a | issue_pkt_i.b;
            OP_XOR:  result = issue_pkt_i.a ^ issue_pkt_i.b;
            // shift amount from the low five bits only
            OP_SLL:  result = issue_pkt_i.a << issue_pkt_i.b[4:0];
            OP_SLT:  result = {{(`XLEN-1){1'b0}},
                               ($signed(issue_pkt_i.a) < $signed(issue_pkt_i.b))};
            OP_BEQ:  result = {{(`XLEN-1){1'b0}}, (issue_pkt_i.a == issue_pkt_i.b)};
            default: result = '0;
        endcase
    end

    // ====================================================================
    // result register
    // ====================================================================

    always_ff @(posedge clock) begin
        if (reset || flush_i) begin
            res_valid_q <= 1'b0;
            res_spec_q  <= 1'b0;
        end else begin
            // marked op killed by a mispredict in its issue cycle
            res_valid_q <= issue_pkt_i.valid && !(squash_i && issue_pkt_i.spec);
            res_spec_q  <= issue_pkt_i.spec && !clear_spec_i;
        end
    end

    always_ff @(posedge clock) begin
        res_tag_q   <= issue_pkt_i.dest;
        res_value_q <= result;
    end

    // still-marked result is held back if squash lands on the broadcast
    assign cdb_o.valid = res_valid_q && !(squash_i && res_spec_q);
    assign cdb_o.tag   = res_tag_q;
    assign cdb_o.value = res_value_q;

endmodule

//--- hdl/rs_top.sv
// reservation station scheduling core, top level
//   speculation control, eight station slots
//   allocation and issue selectors, integer alu with cdb
`timescale 1ns/100ps
`include "rs_defines.svh"

module rs_top import rs_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      disp_valid_i,
    input  disp_pkt_t disp_pkt_i,
    output logic      disp_ready_o,
    input  logic      branch_resolve_i,
    input  logic      mispredict_i,
    input  logic      flush_i,
    output cdb_t      cdb_o
);

    rs_slot_t [`RS_DEPTH-1:0] slots;
    logic     [`RS_DEPTH-1:0] empty_vec;
    logic     [`RS_DEPTH-1:0] ready_vec;
    logic     [`RS_DEPTH-1:0] alloc_vec;
    logic     [`RS_DEPTH-1:0] issue_grant;
    logic                     any_free;
    logic                     write;
    logic                     spec_mark;
    logic                     squash;
    logic                     clear_spec;
    issue_pkt_t               issue_pkt;
    cdb_t                     cdb;

    // ====================================================================
    // dispatch side
    // ====================================================================

    rs_control u_control (
        .clock            (clock),
        .reset            (reset),
        .disp_valid_i     (disp_valid_i),
        .disp_op_i        (disp_pkt_i.op),
        .any_free_i       (any_free),
        .branch_resolve_i (branch_resolve_i),
        .mispredict_i     (mispredict_i),
        .flush_i          (flush_i),
        .disp_ready_o     (disp_ready_o),
        .write_o          (write),
        .spec_mark_o      (spec_mark),
        .squash_o         (squash),
        .clear_spec_o     (clear_spec)
    );

    dispatch_select u_disp_sel (
        .empty_vec_i (empty_vec),
        .alloc_vec_o (alloc_vec),
        .any_free_o  (any_free)
    );

    // ====================================================================
    // station slots
    // ====================================================================

    for (genvar i = 0; i < `RS_DEPTH; i++) begin : g_slot
        // write strobe steered to the allocated slot
        rs_entry u_entry (
            .clock        (clock),
            .reset        (reset),
            .write_i      (write && alloc_vec[i]),
            .pkt_i        (disp_pkt_i),
            .spec_i       (spec_mark),
            .issue_i      (issue_grant[i]),
            .squash_i     (squash),
            .clear_spec_i (clear_spec),
            .flush_i      (flush_i),
            .cdb_i        (cdb),
            .slot_o       (slots[i]),
            .empty_o      (empty_vec[i]),
            .ready_o      (ready_vec[i])
        );
    end

    // ====================================================================
    // issue and execute
    // ====================================================================

    issue_select u_issue_sel (
        .slots_i     (slots),
        .ready_vec_i (ready_vec),
        .grant_o     (issue_grant),
        .issue_pkt_o (issue_pkt)
    );

    int_alu u_alu (
        .clock        (clock),
        .reset        (reset),
        .issue_pkt_i  (issue_pkt),
        .squash_i     (squash),
        .clear_spec_i (clear_spec),
        .flush_i      (flush_i),
        .cdb_o        (cdb)
    );

    // completion is the same broadcast the slots snoop
    assign cdb_o = cdb;

endmodule

//--- testbench/rs_tb.sv
// testbench for the reservation station core
//   clock, reset, dispatch and branch tasks
//   reference alu, cdb scoreboard and monitor
//   six directed and random tests
`timescale 1ns/100ps
`include "rs_defines.svh"

module rs_tb import rs_pkg::*; ();

    localparam int NTAGS = 1 << `TAG_W;
    // consumers of this tag wait until the full test produces it
    localparam logic [`TAG_W-1:0] NEVER_TAG = '1;

    logic      clock;
    logic      reset;
    logic      disp_valid_i;
    disp_pkt_t disp_pkt_i;
    logic      disp_ready_o;
    logic      branch_resolve_i;
    logic      mispredict_i;
    logic      flush_i;
    cdb_t      cdb_o;

    // scoreboard state written by the stimulus side
    logic [`XLEN-1:0]  exp_val [NTAGS];
    int                sent_cnt [NTAGS];
    int                lost_cnt [NTAGS];
    int                acc_cyc [NTAGS];
    bit                ghost [NTAGS];
    bit                killed [NTAGS];
    // owned by the monitor
    int                arrived_cnt [NTAGS];
    int                arr_cyc [NTAGS];
    int                checks;
    int                mon_errors;

    int                cyc;
    int                errors;
    int                err_mark;
    int                tests_run;
    int                tests_failed;
    string             test_name;
    logic [`TAG_W-1:0] next_tag;
    logic [`TAG_W-1:0] ring [8];
    int                ring_n;

    rs_top uut (
        .clock            (clock),
        .reset            (reset),
        .disp_valid_i     (disp_valid_i),
        .disp_pkt_i       (disp_pkt_i),
        .disp_ready_o     (disp_ready_o),
        .branch_resolve_i (branch_resolve_i),
        .mispredict_i     (mispredict_i),
        .flush_i          (flush_i),
        .cdb_o            (cdb_o)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // free-running cycle count for latency checks
    always @(posedge clock) begin
        cyc <= cyc + 1;
    end

    // ======================================================================
    // reference model and scoreboard helpers
    // ======================================================================

    function automatic logic [`XLEN-1:0] ref_alu(input opcode_e op,
                                                 input logic [`XLEN-1:0] a,
                                                 input logic [`XLEN-1:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            // shift amount is b[4:0]
            OP_SLL:  return a << b[4:0];
            OP_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
            default: return (a == b) ? 1 : 0;
        endcase
    endfunction

    function automatic bit is_pending(input int t);
        return sent_cnt[t] != arrived_cnt[t] + lost_cnt[t];
    endfunction

    // operand from an immediate or from a tag that may still be in flight
    function automatic operand_t make_opnd(input bit is_tag, input logic [`XLEN-1:0] x);
        operand_t o;
        o.tag = x[`TAG_W-1:0];
        if (is_tag) begin
            o.rdy   = !(is_pending(int'(o.tag)) || ghost[o.tag]);
            // a waiting operand carries junk that only the cdb may replace
            o.value = o.rdy ? exp_val[o.tag] : ~exp_val[o.tag];
        end else begin
            o.rdy   = 1'b1;
            o.value = x;
        end
        return o;
    endfunction

    // next free tag in 0..59 so that the top tags stay with the directed tests
    function automatic logic [`TAG_W-1:0] alloc_tag();
        logic [`TAG_W-1:0] t;
        t = next_tag;
        for (int n = 0; n < NTAGS; n++) begin
            t        = next_tag;
            next_tag = (next_tag >= 6'd59) ? 6'd0 : next_tag + 6'd1;
            if (!is_pending(int'(t))) begin
                return t;
            end
        end
        return t;
    endfunction

    // ======================================================================
    // cdb monitor
    // ======================================================================

    always @(negedge clock) begin
        if (!reset && cdb_o.valid) begin
            checks = checks + 1;
            if (killed[cdb_o.tag]) begin
                $display("error: test %s squashed tag %0d appeared on the cdb",
                         test_name, cdb_o.tag);
                mon_errors = mon_errors + 1;
            end else if (!is_pending(int'(cdb_o.tag))) begin
                $display("error: test %s unexpected broadcast for tag %0d",
                         test_name, cdb_o.tag);
                mon_errors = mon_errors + 1;
            end else begin
                if (cdb_o.value !== exp_val[cdb_o.tag]) begin
                    $display("mismatch test %s tag %0d expected %h actual %h",
                             test_name, cdb_o.tag, exp_val[cdb_o.tag], cdb_o.value);
                    mon_errors = mon_errors + 1;
                end
                arrived_cnt[cdb_o.tag] = arrived_cnt[cdb_o.tag] + 1;
                arr_cyc[cdb_o.tag]     = cyc;
            end
        end
    end

    // ======================================================================
    // stimulus tasks
    // ======================================================================

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clock);
            #1;
        end
    endtask

    task automatic send(input opcode_e op, input logic [`TAG_W-1:0] dest,
                        input bit a_tag, input logic [`XLEN-1:0] a,
                        input bit b_tag, input logic [`XLEN-1:0] b,
                        input bit track);
        operand_t         oa;
        operand_t         ob;
        logic [`XLEN-1:0] a_val;
        logic [`XLEN-1:0] b_val;
        bit               taken;
        int               waited;
        // values the result is built from, whether ready yet or not
        a_val = a_tag ? exp_val[a[`TAG_W-1:0]] : a;
        b_val = b_tag ? exp_val[b[`TAG_W-1:0]] : b;
        oa = make_opnd(a_tag, a);
        ob = make_opnd(b_tag, b);
        if (track) begin
            exp_val[dest]  = ref_alu(op, a_val, b_val);
            sent_cnt[dest] = sent_cnt[dest] + 1;
        end
        taken  = 1'b0;
        waited = 0;
        while (!taken && waited < 100) begin
            disp_valid_i     = 1'b1;
            disp_pkt_i.op    = op;
            disp_pkt_i.dest  = dest;
            disp_pkt_i.src_a = oa;
            disp_pkt_i.src_b = ob;
            @(negedge clock);
            taken         = disp_ready_o;
            acc_cyc[dest] = cyc;
            @(posedge clock);
            #1;
            // producer broadcast while the packet was held back
            if (!oa.rdy && !is_pending(int'(oa.tag)) && !ghost[oa.tag]) begin
                oa.rdy   = 1'b1;
                oa.value = a_val;
            end
            if (!ob.rdy && !is_pending(int'(ob.tag)) && !ghost[ob.tag]) begin
                ob.rdy   = 1'b1;
                ob.value = b_val;
            end
            waited++;
        end
        disp_valid_i = 1'b0;
        if (!taken) begin
            $display("error: test %s dispatch of tag %0d was never accepted", test_name, dest);
            errors++;
        end
    endtask

    task automatic resolve(input bit mis);
        branch_resolve_i = 1'b1;
        mispredict_i     = mis;
        @(posedge clock);
        #1;
        branch_resolve_i = 1'b0;
        mispredict_i     = 1'b0;
    endtask

    task automatic wait_all(input int limit);
        int waited;
        bit busy;
        waited = 0;
        busy   = 1'b1;
        while (busy && waited < limit) begin
            @(posedge clock);
            #1;
            waited++;
            busy = 1'b0;
            for (int t = 0; t < NTAGS; t++) begin
                if (is_pending(t)) begin
                    busy = 1'b1;
                end
            end
        end
        if (busy) begin
            for (int t = 0; t < NTAGS; t++) begin
                if (is_pending(t)) begin
                    $display("error: test %s tag %0d never arrived on the cdb", test_name, t);
                    lost_cnt[t] = sent_cnt[t] - arrived_cnt[t];
                end
            end
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_mark  = errors + mon_errors;
        tests_run++;
    endtask

    task automatic end_test();
        // quiet period so late squashed broadcasts still get caught
        idle(4);
        for (int t = 0; t < NTAGS; t++) begin
            killed[t] = 1'b0;
        end
        if (errors + mon_errors == err_mark) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, errors + mon_errors - err_mark);
            tests_failed++;
        end
    endtask

    // ======================================================================
    // tests
    // ======================================================================

    task automatic run_independent();
        opcode_e           op;
        logic [`TAG_W-1:0] t;
        logic [`XLEN-1:0]  a;
        logic [`XLEN-1:0]  b;
        begin_test("independent");
        for (int i = 0; i < 8; i++) begin
            op = opcode_e'(3'(i));
            t  = `TAG_W'(i + 1);
            a  = $urandom;
            b  = (op == OP_BEQ) ? a : $urandom;
            send(op, t, 1'b0, a, 1'b0, b, 1'b1);
            wait_all(20);
            // handshake cycle to broadcast cycle
            if (arr_cyc[t] - acc_cyc[t] != 2) begin
                $display("mismatch test %s latency of tag %0d expected 2 actual %0d",
                         test_name, t, arr_cyc[t] - acc_cyc[t]);
                errors++;
            end
        end
        // close the window opened by the beq
        resolve(1'b0);
        end_test();
    endtask

    task automatic run_chain();
        opcode_e ops [5];
        begin_test("chain");
        ops = '{OP_ADD, OP_SUB, OP_XOR, OP_SLL, OP_OR};
        send(ops[0], 6'd20, 1'b0, $urandom, 1'b0, $urandom, 1'b1);
        for (int i = 1; i < 5; i++) begin
            send(ops[i], `TAG_W'(20 + i), 1'b1, `XLEN'(19 + i), 1'b0, $urandom, 1'b1);
        end
        wait_all(100);
        for (int i = 1; i < 5; i++) begin
            if (arr_cyc[20 + i] <= arr_cyc[19 + i]) begin
                $display("error: test %s tag %0d arrived before its producer",
                         test_name, 20 + i);
                errors++;
            end
        end
        end_test();
    endtask

    task automatic run_full();
        begin_test("full");
        for (int i = 0; i < 8; i++) begin
            killed[40 + i] = 1'b1;
            send(OP_ADD, `TAG_W'(40 + i), 1'b1, `XLEN'(NEVER_TAG), 1'b0, $urandom, 1'b0);
        end
        @(negedge clock);
        if (disp_ready_o !== 1'b0) begin
            $display("error: test %s station is full but dispatch is still ready", test_name);
            errors++;
        end
        @(posedge clock);
        #1;
        flush_i = 1'b1;
        @(posedge clock);
        #1;
        flush_i = 1'b0;
        @(negedge clock);
        if (disp_ready_o !== 1'b1) begin
            $display("error: test %s dispatch not ready after the flush", test_name);
            errors++;
        end
        @(posedge clock);
        #1;
        // producing the tag wakes any consumer the flush left behind
        send(OP_OR, NEVER_TAG, 1'b0, $urandom, 1'b0, $urandom, 1'b1);
        wait_all(20);
        end_test();
    endtask

    // branch followed by marked work that waits on tag 12 until after the resolve
    task automatic run_spec(input bit mis);
        logic [`XLEN-1:0] pa;
        logic [`XLEN-1:0] pb;
        bit               leaked;
        begin_test(mis ? "mispredict" : "predict");
        pa = $urandom;
        pb = $urandom;
        send(OP_SUB, 6'd10, 1'b0, $urandom, 1'b0, $urandom, 1'b1);
        send(OP_BEQ, 6'd11, 1'b0, pa, 1'b0, pb, 1'b1);
        exp_val[12] = ref_alu(OP_ADD, pa, pb);
        ghost[12]   = 1'b1;
        killed[13]  = mis;
        killed[14]  = mis;
        send(OP_XOR, 6'd13, 1'b1, 32'd12, 1'b0, $urandom, !mis);
        send(OP_SLT, 6'd14, 1'b0, $urandom, 1'b1, 32'd12, !mis);
        // a second branch has to stall
        leaked          = 1'b0;
        disp_valid_i    = 1'b1;
        disp_pkt_i.op   = OP_BEQ;
        disp_pkt_i.dest = 6'd15;
        repeat (3) begin
            @(negedge clock);
            if (disp_ready_o) begin
                leaked = 1'b1;
            end
            @(posedge clock);
            #1;
        end
        disp_valid_i = 1'b0;
        if (leaked) begin
            $display("error: test %s second branch accepted while one was pending", test_name);
            errors++;
        end
        resolve(mis);
        ghost[12] = 1'b0;
        send(OP_ADD, 6'd12, 1'b0, pa, 1'b0, pb, 1'b1);
        wait_all(50);
        end_test();
    endtask

    task automatic run_random();
        opcode_e           op;
        logic [`TAG_W-1:0] t;
        logic [`XLEN-1:0]  a;
        logic [`XLEN-1:0]  b;
        bit                a_tag;
        bit                b_tag;
        begin_test("random");
        ring_n = 0;
        for (int i = 0; i < 200; i++) begin
            // no beq here since nothing would resolve it
            op    = opcode_e'(3'($urandom % 7));
            a_tag = (ring_n > 0) && ($urandom % 2 == 1);
            b_tag = (ring_n > 0) && ($urandom % 2 == 1);
            a     = a_tag ? `XLEN'(ring[$urandom % ring_n]) : $urandom;
            b     = b_tag ? `XLEN'(ring[$urandom % ring_n]) : $urandom;
            t     = alloc_tag();
            send(op, t, a_tag, a, b_tag, b, 1'b1);
            ring[i % 8] = t;
            if (ring_n < 8) begin
                ring_n++;
            end
            idle($urandom % 3);
        end
        wait_all(400);
        end_test();
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================

    initial begin
        void'($urandom(32'h8bdb_6976));
        reset            = 1'b1;
        disp_valid_i     = 1'b0;
        disp_pkt_i       = '0;
        branch_resolve_i = 1'b0;
        mispredict_i     = 1'b0;
        flush_i          = 1'b0;
        next_tag         = '0;
        test_name        = "reset";
        ghost[NEVER_TAG] = 1'b1;
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;
        @(negedge clock);
        if (disp_ready_o !== 1'b1 || cdb_o.valid !== 1'b0) begin
            $display("error: outputs are not idle after reset");
            errors++;
        end
        @(posedge clock);
        #1;
        run_independent();
        run_chain();
        run_full();
        run_spec(1'b1);
        run_spec(1'b0);
        run_random();
        $display("tests %0d, failed %0d, cdb checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors + mon_errors);
        if (tests_failed == 0 && errors + mon_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+hdl
hdl/rs_pkg.sv
hdl/rs_control.sv
hdl/rs_entry.sv
hdl/dispatch_select.sv
hdl/issue_select.sv
hdl/int_alu.sv
hdl/rs_top.sv
testbench/rs_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the reservation station testbench with verilator and run it
rm -rf obj_dir build.log sim.log
verilator --binary --timing -f tb.f --top-module rs_tb -o rs_sim > build.log 2>&1 ||
    { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/rs_sim > sim.log 2>&1
grep -qx "all tests passed" sim.log && echo "simulation passed" && exit 0
echo "simulation failed, see sim.log"
exit 1
